// ==== logic/prbs_types_pkg.sv ====
////////////////////////////////////////////////////////////
// Mode 2 is a repeated octet and not PRBS31
// Octet lane 0 is the least significant byte of a word
////////////////////////////////////////////////////////////
`default_nettype none

package prbs_types_pkg;

    // Pattern selection, 2-bit field of the CTRL register
    typedef enum logic [1:0] {
        mode_prbs15 = 2'd0,
        mode_prbs23 = 2'd1,
        mode_fixed  = 2'd2,
        mode_count  = 2'd3
    } pattern_mode_e;

    // Same 32 bits seen as LFSR state or as four octet lanes
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  octet;
    } pattern_word_u;

    // Restart value when an LFSR has locked up at zero
    localparam logic [31:0] PRBS_RESET_WORD = 32'hffff_fffe;

    // Feedback taps, x^15 + x^14 + 1 and x^23 + x^18 + 1
    localparam int PRBS15_TAP_A = 14;
    localparam int PRBS15_TAP_B = 13;
    localparam int PRBS23_TAP_A = 22;
    localparam int PRBS23_TAP_B = 17;

    // Frame end markers
    localparam logic [14:0] FRAME_MARK_15  = 15'h1234;
    localparam logic [22:0] FRAME_MARK_23  = 23'h12_3456;
    localparam logic [30:0] FRAME_MARK_FIX = 31'h1234_5678;
    localparam logic [7:0]  FRAME_MARK_CNT = 8'h12;

    localparam int OCTETS_MAX = 4;

endpackage

`default_nettype wire

// ==== logic/cfg_regs_pkg.sv ====
////////////////////////////////////////////////////////////
// Four 32-bit registers on a 2-bit address
// Counters are CNT_W wide and zero-extended on read
////////////////////////////////////////////////////////////
`default_nettype none

package cfg_regs_pkg;

    ////////////////////////////////////////////////////////////
    // Register map

    localparam logic [1:0] REG_CTRL      = 2'd0;
    localparam logic [1:0] REG_SEED      = 2'd1;
    // Any write here clears both monitor counters
    localparam logic [1:0] REG_ERR_CNT   = 2'd2;
    localparam logic [1:0] REG_FRAME_CNT = 2'd3;

    ////////////////////////////////////////////////////////////
    // CTRL fields

    // mode is 2 bits wide
    localparam int CTRL_MODE_LSB = 0;
    // Octet count, 0 means four
    localparam int CTRL_NOB_LSB = 2;
    localparam int CTRL_GEN_EN_BIT = 4;
    localparam int CTRL_MON_EN_BIT = 5;

    // Error and frame counters
    localparam int CNT_W = 16;

endpackage

`default_nettype wire

// ==== logic/prbs_next.sv ====
////////////////////////////////////////////////////////////
// Purely combinational, one to four octets per call
// nob of 0 means four octets
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prbs_next
    import prbs_types_pkg::*;
(
    input  pattern_word_u cur,
    input  pattern_mode_e mode,
    input  logic [1:0]    nob,
    output pattern_word_u nxt,
    output logic          end_frame
);

    // Eight serial LFSR shifts, new bits enter at bit 0
    function automatic logic [31:0] lfsr_octet(
        input logic [31:0] s,
        input int          tap_a,
        input int          tap_b
    );
        logic [31:0] r;
        r = s;
        for (int b = 0; b < 8; b++) begin
            r = {r[30:0], r[tap_a] ^ r[tap_b]};
        end
        return r;
    endfunction

    logic [2:0]    n_oct;
    logic          zero_state;
    logic          cnt_hit;
    pattern_word_u prbs15_w;
    pattern_word_u prbs23_w;
    pattern_word_u cnt_w;
    pattern_word_u fix_w;

    assign n_oct      = (nob == 2'd0) ? 3'(OCTETS_MAX) : {1'b0, nob};
    assign zero_state = (cur.word == '0);

    ////////////////////////////////////////////////////////////
    // PRBS chains, one step per active octet

    always_comb begin : prbs_steps
        prbs15_w = cur;
        prbs23_w = cur;
        for (int k = 0; k < OCTETS_MAX; k++) begin
            if (k < n_oct) begin
                prbs15_w.word = lfsr_octet(prbs15_w.word, PRBS15_TAP_A, PRBS15_TAP_B);
                prbs23_w.word = lfsr_octet(prbs23_w.word, PRBS23_TAP_A, PRBS23_TAP_B);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Octet patterns

    // Old lanes move up by n, new lanes count on from lane 0
    always_comb begin : count_pattern
        for (int k = 0; k < OCTETS_MAX; k++) begin
            if (k < n_oct) begin
                cnt_w.octet[k] = cur.octet[0] + 8'(n_oct - k);
            end else begin
                cnt_w.octet[k] = cur.octet[k - n_oct];
            end
        end
    end

    // Lane 0 copied to every lane
    always_comb begin : fixed_pattern
        for (int k = 0; k < OCTETS_MAX; k++) begin
            fix_w.octet[k] = cur.octet[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Output select

    always_comb begin : out_sel
        if (mode == mode_count) begin
            nxt = cnt_w;
        end else if (zero_state) begin
            // Stuck LFSR, restart it
            nxt.word = PRBS_RESET_WORD;
        end else begin
            case (mode)
                mode_prbs15: nxt = prbs15_w;
                mode_prbs23: nxt = prbs23_w;
                default:     nxt = fix_w;
            endcase
        end
    end

    // Any freshly inserted counter octet on the mark
    always_comb begin : count_mark
        cnt_hit = 1'b0;
        for (int k = 0; k < OCTETS_MAX; k++) begin
            if ((k < n_oct) && (cnt_w.octet[k] == FRAME_MARK_CNT)) begin
                cnt_hit = 1'b1;
            end
        end
    end

    always_comb begin : frame_end
        case (mode)
            mode_prbs15: end_frame = (cur.word[14:0] == FRAME_MARK_15);
            mode_prbs23: end_frame = (cur.word[22:0] == FRAME_MARK_23);
            mode_fixed:  end_frame = (cur.word[30:0] == FRAME_MARK_FIX);
            default:     end_frame = cnt_hit;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/prbs_gen.sv ====
////////////////////////////////////////////////////////////
// One new word per clock while enabled, no back-pressure
// tx_valid lags gen_en by one clock
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prbs_gen
    import prbs_types_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          gen_en,
    input  logic          seed_load,
    input  logic [31:0]   seed,
    input  pattern_mode_e mode,
    input  logic [1:0]    nob,
    output logic [31:0]   tx_data,
    output logic          tx_valid
);

    pattern_word_u state;
    pattern_word_u state_nxt;
    logic          valid_q;

    // Next word, frame flag only matters on the receive side
    prbs_next u_next (
        .cur       (state),
        .mode      (mode),
        .nob       (nob),
        .nxt       (state_nxt),
        .end_frame ()
    );

    ////////////////////////////////////////////////////////////
    // State register

    always_ff @(posedge clk) begin
        if (rst) begin
            state.word <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= gen_en;
            // Seed wins over the advance
            if (seed_load) begin
                state.word <= seed;
            end else if (valid_q) begin
                state <= state_nxt;
            end
        end
    end

    assign tx_data  = state.word;
    assign tx_valid = valid_q;

endmodule

`default_nettype wire

// ==== logic/prbs_mon.sv ====
////////////////////////////////////////////////////////////
// Predicts each word from the last one received
// One corrupt word normally costs two errors
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prbs_mon
    import prbs_types_pkg::*;
    import cfg_regs_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             mon_en,
    input  logic             count_clear,
    input  logic [31:0]      rx_data,
    input  logic             rx_valid,
    input  pattern_mode_e    mode,
    input  logic [1:0]       nob,
    output logic [CNT_W-1:0] err_cnt,
    output logic [CNT_W-1:0] frame_cnt
);

    pattern_word_u last_word;
    pattern_word_u predict;
    logic          predict_end;
    logic          primed;
    logic          mismatch;

    prbs_next u_next (
        .cur       (last_word),
        .mode      (mode),
        .nob       (nob),
        .nxt       (predict),
        .end_frame (predict_end)
    );

    assign mismatch = (predict.word != rx_data);

    ////////////////////////////////////////////////////////////
    // Prediction base, follows every valid word

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            last_word.word <= rx_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Priming and counters

    always_ff @(posedge clk) begin
        if (rst) begin
            primed    <= 1'b0;
            err_cnt   <= '0;
            frame_cnt <= '0;
        end else if (count_clear) begin
            primed    <= 1'b0;
            err_cnt   <= '0;
            frame_cnt <= '0;
        end else if (!mon_en) begin
            primed <= 1'b0;
        end else if (rx_valid) begin
            primed <= 1'b1;
            // First word after enable or clear only seeds the prediction
            if (primed) begin
                if (mismatch && (err_cnt != '1)) begin
                    err_cnt <= err_cnt + 1'b1;
                end
                if (predict_end) begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pattern_cfg_regs.sv ====
////////////////////////////////////////////////////////////
// Writes land on the strobe edge, read data one clock later
// seed_load and count_clear follow a write by one clock
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pattern_cfg_regs
    import prbs_types_pkg::*;
    import cfg_regs_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             reg_wr,
    input  logic             reg_rd,
    input  logic [1:0]       reg_addr,
    input  logic [31:0]      reg_wdata,
    input  logic [CNT_W-1:0] err_cnt,
    input  logic [CNT_W-1:0] frame_cnt,
    output logic [31:0]      reg_rdata,
    output pattern_mode_e    mode,
    output logic [1:0]       nob,
    output logic             gen_en,
    output logic             mon_en,
    output logic [31:0]      seed,
    output logic             seed_load,
    output logic             count_clear
);

    logic [31:0] ctrl_word;
    logic [31:0] rd_mux;

    ////////////////////////////////////////////////////////////
    // Write side

    always_ff @(posedge clk) begin
        if (rst) begin
            mode        <= mode_prbs15;
            nob         <= 2'd0;
            gen_en      <= 1'b0;
            mon_en      <= 1'b0;
            seed        <= '0;
            seed_load   <= 1'b0;
            count_clear <= 1'b0;
        end else begin
            seed_load   <= reg_wr && (reg_addr == REG_SEED);
            count_clear <= reg_wr && (reg_addr == REG_ERR_CNT);
            if (reg_wr && (reg_addr == REG_CTRL)) begin
                mode   <= pattern_mode_e'(reg_wdata[CTRL_MODE_LSB +: 2]);
                nob    <= reg_wdata[CTRL_NOB_LSB +: 2];
                gen_en <= reg_wdata[CTRL_GEN_EN_BIT];
                mon_en <= reg_wdata[CTRL_MON_EN_BIT];
            end
            if (reg_wr && (reg_addr == REG_SEED)) begin
                seed <= reg_wdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side

    always_comb begin : ctrl_pack
        ctrl_word                          = '0;
        ctrl_word[CTRL_MODE_LSB +: 2]      = mode;
        ctrl_word[CTRL_NOB_LSB +: 2]       = nob;
        ctrl_word[CTRL_GEN_EN_BIT]         = gen_en;
        ctrl_word[CTRL_MON_EN_BIT]         = mon_en;
    end

    always_comb begin : read_sel
        case (reg_addr)
            REG_CTRL:    rd_mux = ctrl_word;
            REG_SEED:    rd_mux = seed;
            REG_ERR_CNT: rd_mux = 32'(err_cnt);
            default:     rd_mux = 32'(frame_cnt);
        endcase
    end

    // Holds its value between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pattern_top.sv ====
////////////////////////////////////////////////////////////
// Single clock, rx side is expected to be looped from tx
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pattern_top
    import prbs_types_pkg::*;
    import cfg_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_wr,
    input  logic        reg_rd,
    input  logic [1:0]  reg_addr,
    input  logic [31:0] reg_wdata,
    output logic [31:0] reg_rdata,
    input  logic [31:0] rx_data,
    input  logic        rx_valid,
    output logic [31:0] tx_data,
    output logic        tx_valid
);

    pattern_mode_e    mode;
    logic [1:0]       nob;
    logic             gen_en;
    logic             mon_en;
    logic [31:0]      seed;
    logic             seed_load;
    logic             count_clear;
    logic [CNT_W-1:0] err_cnt;
    logic [CNT_W-1:0] frame_cnt;

    pattern_cfg_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .err_cnt     (err_cnt),
        .frame_cnt   (frame_cnt),
        .reg_rdata   (reg_rdata),
        .mode        (mode),
        .nob         (nob),
        .gen_en      (gen_en),
        .mon_en      (mon_en),
        .seed        (seed),
        .seed_load   (seed_load),
        .count_clear (count_clear)
    );

    // Transmit side
    prbs_gen u_gen (
        .clk       (clk),
        .rst       (rst),
        .gen_en    (gen_en),
        .seed_load (seed_load),
        .seed      (seed),
        .mode      (mode),
        .nob       (nob),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid)
    );

    // Receive side checker
    prbs_mon u_mon (
        .clk         (clk),
        .rst         (rst),
        .mon_en      (mon_en),
        .count_clear (count_clear),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .mode        (mode),
        .nob         (nob),
        .err_cnt     (err_cnt),
        .frame_cnt   (frame_cnt)
    );

endmodule

`default_nettype wire

// ==== tb/pattern_assertions.sv ====
////////////////////////////////////////////////////////////
// Bound into pattern_top, sees its ports and two internals
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pattern_assertions
    import prbs_types_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input logic          tx_valid,
    input logic [31:0]   tx_data,
    input logic          reg_rd,
    input logic [31:0]   reg_rdata,
    input pattern_mode_e mode,
    input logic          seed_load
);

    // Failures so far, read by the testbench at the end
    int assert_fails = 0;

    property valid_low_after_reset;
        @(posedge clk) rst |=> !tx_valid;
    endproperty

    // A PRBS word never repeats on the next valid cycle
    property prbs_word_moves;
        @(posedge clk) disable iff (rst)
            (tx_valid && !seed_load && ((mode == mode_prbs15) || (mode == mode_prbs23)))
            |=> (tx_data != $past(tx_data));
    endproperty

    property rdata_holds;
        @(posedge clk) disable iff (rst) !reg_rd |=> $stable(reg_rdata);
    endproperty

    a_valid_low: assert property (valid_low_after_reset) else begin
        assert_fails++;
        $error("tx_valid is high in the cycle after reset");
    end

    a_prbs_moves: assert property (prbs_word_moves) else begin
        assert_fails++;
        $error("tx_data did not change after a valid PRBS cycle");
    end

    a_rdata_holds: assert property (rdata_holds) else begin
        assert_fails++;
        $error("reg_rdata changed without a read");
    end

endmodule

`default_nettype wire

// ==== tb/tb_pattern_top.sv ====
////////////////////////////////////////////////////////////
// tx is looped to rx through a flip mask driven here
// Expected words come from a bit-serial model of the pattern rules
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_pattern_top
    import prbs_types_pkg::*;
    import cfg_regs_pkg::*;
();

    localparam int PRBS_WORDS  = 200;
    localparam int COUNT_WORDS = 300;
    localparam int SHORT_WORDS = 64;
    localparam int FLIP_WORDS  = 400;
    // PRBS15 low bits repeat after 32767 words
    localparam int WRAP_WORDS  = 33000;
    localparam int NUM_RUNS    = 17;
    localparam int RUN_CYCLES  = 40;
    localparam int TEST_CYCLES = 8 * PRBS_WORDS + 4 * COUNT_WORDS + 3 * SHORT_WORDS
                               + FLIP_WORDS + WRAP_WORDS + NUM_RUNS * RUN_CYCLES + 100;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

    logic        clk;
    logic        rst;
    logic        reg_wr;
    logic        reg_rd;
    logic [1:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic [31:0] rx_data;
    logic        rx_valid;
    logic [31:0] tx_data;
    logic        tx_valid;
    logic [31:0] corrupt = '0;

    // Reference model state, advanced once per valid word
    pattern_word_u exp_word;
    pattern_word_u prev_rx;
    pattern_mode_e run_mode;
    logic [1:0]    run_nob;
    string         run_name;
    bit            tracking    = 1'b0;
    int            words_seen  = 0;
    int            err_exp     = 0;
    int            frame_exp   = 0;
    int            flip_period = 0;
    int            value_errs  = 0;
    int            other_errs  = 0;

    pattern_top UUT (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid)
    );

    bind pattern_top pattern_assertions u_assert (
        .clk       (clk),
        .rst       (rst),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .reg_rd    (reg_rd),
        .reg_rdata (reg_rdata),
        .mode      (mode),
        .seed_load (seed_load)
    );

    // External loopback
    assign rx_data  = tx_data ^ corrupt;
    assign rx_valid = tx_valid;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic pattern_word_u model_next(pattern_word_u w, pattern_mode_e m,
                                                 logic [1:0] nob);
        pattern_word_u r;
        int            n;
        int            ta;
        int            tb;
        logic          fb;
        n  = (nob == 2'd0) ? 4 : int'(nob);
        ta = (m == mode_prbs15) ? PRBS15_TAP_A : PRBS23_TAP_A;
        tb = (m == mode_prbs15) ? PRBS15_TAP_B : PRBS23_TAP_B;
        r  = w;
        if (m == mode_count) begin
            // Shift in one counter octet at a time
            for (int i = 0; i < n; i++) begin
                r.word = {r.word[23:0], 8'(r.octet[0] + 8'd1)};
            end
        end else if (w.word == 32'h0) begin
            r.word = PRBS_RESET_WORD;
        end else if (m == mode_fixed) begin
            r.word = {4{w.octet[0]}};
        end else begin
            for (int i = 0; i < 8 * n; i++) begin
                fb     = r.word[ta] ^ r.word[tb];
                r.word = {r.word[30:0], fb};
            end
        end
        return r;
    endfunction

    function automatic bit model_end(pattern_word_u w, pattern_mode_e m, logic [1:0] nob);
        int n;
        bit hit;
        n   = (nob == 2'd0) ? 4 : int'(nob);
        hit = 1'b0;
        case (m)
            mode_prbs15: hit = (w.word[14:0] == FRAME_MARK_15);
            mode_prbs23: hit = (w.word[22:0] == FRAME_MARK_23);
            mode_fixed:  hit = (w.word[30:0] == FRAME_MARK_FIX);
            default: begin
                for (int i = 1; i <= n; i++) begin
                    if (8'(w.octet[0] + i) == FRAME_MARK_CNT) begin
                        hit = 1'b1;
                    end
                end
            end
        endcase
        return hit;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks and bus access

    task automatic check_word(input string name, input pattern_word_u exp,
                              input pattern_word_u act);
        if (act.word !== exp.word) begin
            value_errs++;
            $display("Error %s: expected %h, actual %h", name, exp.word, act.word);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd   = 1'b0;
        data     = reg_rdata;
    endtask

    task automatic wait_words(input string name, input int n);
        int guard;
        guard = 0;
        while ((words_seen < n) && (guard < n + 50)) begin
            @(negedge clk);
            guard++;
        end
        if (words_seen < n) begin
            other_errs++;
            $display("%s: only %0d of %0d words arrived before the timeout", name, words_seen, n);
        end
    endtask

    // Checks every tx word against the model and counts expected monitor events
    always @(negedge clk) begin : tracker
        pattern_word_u rx_w;
        if (tracking && tx_valid) begin
            check_word(run_name, exp_word, tx_data);
            if ((flip_period > 0) && ((words_seen % flip_period) == flip_period / 2)) begin
                corrupt = $urandom() | 32'h1;
            end else begin
                corrupt = '0;
            end
            rx_w.word = exp_word.word ^ corrupt;
            if (words_seen > 0) begin
                if (model_next(prev_rx, run_mode, run_nob) != rx_w) begin
                    err_exp++;
                end
                if (model_end(prev_rx, run_mode, run_nob)) begin
                    frame_exp++;
                end
            end
            prev_rx  = rx_w;
            exp_word = model_next(exp_word, run_mode, run_nob);
            words_seen++;
        end else begin
            corrupt = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic reset_values();
        logic [31:0] rd;
        if (tx_valid !== 1'b0) begin
            other_errs++;
            $display("reset_values: tx_valid is not low after reset");
        end
        reg_read(REG_CTRL, rd);
        check_word("reset_ctrl", 32'h0, rd);
        reg_read(REG_SEED, rd);
        check_word("reset_seed", 32'h0, rd);
        reg_read(REG_ERR_CNT, rd);
        check_count("reset_err_cnt", '0, rd[CNT_W-1:0]);
        reg_read(REG_FRAME_CNT, rd);
        check_count("reset_frame_cnt", '0, rd[CNT_W-1:0]);
    endtask

    task automatic run_stream(input string name, input pattern_mode_e m, input logic [1:0] nob,
                              input logic [31:0] seed, input int n, input int period);
        logic [31:0] ctrl;
        logic [31:0] rd;
        ctrl = (32'(m) << CTRL_MODE_LSB) | (32'(nob) << CTRL_NOB_LSB);
        reg_write(REG_CTRL, ctrl);
        repeat (3) @(negedge clk);
        run_name       = name;
        run_mode       = m;
        run_nob        = nob;
        exp_word.word  = seed;
        words_seen     = 0;
        err_exp        = 0;
        frame_exp      = 0;
        flip_period    = period;
        tracking       = 1'b1;
        reg_write(REG_SEED, seed);
        reg_write(REG_ERR_CNT, 32'h0);
        reg_write(REG_CTRL, ctrl | (32'd1 << CTRL_GEN_EN_BIT) | (32'd1 << CTRL_MON_EN_BIT));
        wait_words(name, n);
        // Stop the generator, the monitor sees the trailing words
        reg_write(REG_CTRL, ctrl | (32'd1 << CTRL_MON_EN_BIT));
        repeat (4) @(negedge clk);
        tracking = 1'b0;
        reg_read(REG_ERR_CNT, rd);
        check_count({name, "_err_cnt"}, CNT_W'(err_exp), rd[CNT_W-1:0]);
        reg_read(REG_FRAME_CNT, rd);
        check_count({name, "_frame_cnt"}, CNT_W'(frame_exp), rd[CNT_W-1:0]);
    endtask

    task automatic clear_counts(input string name);
        logic [31:0] rd;
        reg_write(REG_ERR_CNT, 32'hffff_ffff);
        @(negedge clk);
        reg_read(REG_ERR_CNT, rd);
        check_count({name, "_err_cnt"}, '0, rd[CNT_W-1:0]);
        reg_read(REG_FRAME_CNT, rd);
        check_count({name, "_frame_cnt"}, '0, rd[CNT_W-1:0]);
    endtask

    initial begin : main_seq
        void'($urandom(32'h1a64));
        rst       = 1'b1;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        reset_values();
        for (int nb = 0; nb < 4; nb++) begin
            run_stream($sformatf("prbs15_nob%0d", nb), mode_prbs15, 2'(nb), $urandom(),
                       PRBS_WORDS, 0);
            run_stream($sformatf("prbs23_nob%0d", nb), mode_prbs23, 2'(nb), $urandom(),
                       PRBS_WORDS, 0);
            run_stream($sformatf("count_nob%0d", nb), mode_count, 2'(nb), $urandom(),
                       COUNT_WORDS, 0);
        end
        run_stream("prbs15_zero_seed", mode_prbs15, 2'd1, 32'h0, SHORT_WORDS, 0);
        run_stream("fixed_random", mode_fixed, 2'd2, $urandom(), SHORT_WORDS, 0);
        run_stream("fixed_mark", mode_fixed, 2'd3, 32'h1234_5678, SHORT_WORDS, 0);
        // Isolated flips, two errors each
        run_stream("prbs23_flips", mode_prbs23, 2'd0, $urandom(), FLIP_WORDS, 37);
        clear_counts("err_clear");
        run_stream("prbs15_wrap", mode_prbs15, 2'd0, $urandom(), WRAP_WORDS, 0);
        if (frame_exp == 0) begin
            other_errs++;
            $display("prbs15_wrap: the frame mark never occurred during the wrap run");
        end
        $display("Error counts: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, UUT.u_assert.assert_fails);
        if ((value_errs + other_errs + UUT.u_assert.assert_fails) == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/prbs_types_pkg.sv
logic/cfg_regs_pkg.sv
logic/prbs_next.sv
logic/prbs_gen.sv
logic/prbs_mon.sv
logic/pattern_cfg_regs.sv
logic/pattern_top.sv
tb/pattern_assertions.sv
tb/tb_pattern_top.sv

// ==== Bender.yml ====
package:
  name: pattern_checker

sources:
  # Packages before the modules that import them
  - logic/prbs_types_pkg.sv
  - logic/cfg_regs_pkg.sv
  - logic/prbs_next.sv
  - logic/prbs_gen.sv
  - logic/prbs_mon.sv
  - logic/pattern_cfg_regs.sv
  - logic/pattern_top.sv

  # Testbench, top module tb_pattern_top
  - target: test
    files:
      - tb/pattern_assertions.sv
      - tb/tb_pattern_top.sv
